//--- Makefile
# Verilator build and run for the RTOS kernel core testbench

VERILATOR ?= verilator
TOP       ?= rtos_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/rtos_pkg.sv
package rtos_pkg;

    localparam int NUM_TASKS      = 4;
    localparam int TSKID_WIDTH    = 2;
    localparam int TSKPRI_WIDTH   = 2;
    localparam int FLGPTN_WIDTH   = 8;
    localparam int RELTIM_WIDTH   = 16;
    localparam int PARAM_WIDTH    = 16;
    localparam int WFMODE_BIT     = 8;

    localparam int                   SEM_WIDTH = 2;
    localparam logic [SEM_WIDTH-1:0] SEM_INIT  = 2'd1;
    localparam logic [SEM_WIDTH-1:0] SEM_MAX   = 2'd3;

    localparam int TICK_DIV       = 4;
    localparam int TICK_CNT_WIDTH = $clog2(TICK_DIV);

    // flag wait modes, taken from bit 8 of the command parameter
    localparam logic WF_AND = 1'b0;
    localparam logic WF_OR  = 1'b1;

    typedef enum logic [2:0] {
        TS_SLEEP  = 3'h0,
        TS_REQRDY = 3'h1,
        TS_READY  = 3'h2,
        TS_DELAY  = 3'h3,
        TS_WAISEM = 3'h4,
        TS_WAIFLG = 3'h5
    } tskstat_t;

    typedef enum logic [3:0] {
        OP_WUP_TSK = 4'h0,
        OP_SLP_TSK = 4'h1,
        OP_REL_WAI = 4'h2,
        OP_DLY_TSK = 4'h3,
        OP_WAI_SEM = 4'h4,
        OP_SIG_SEM = 4'h5,
        OP_WAI_FLG = 4'h6,
        OP_SET_FLG = 4'h7,
        OP_CLR_FLG = 4'h8
    } opcode_t;

    // returns {found, id} of the candidate with the smallest priority value,
    // the lower id wins a tie
    function automatic logic [TSKID_WIDTH:0] pick_task(
        input logic [NUM_TASKS-1:0]                   cand,
        input logic [NUM_TASKS-1:0][TSKPRI_WIDTH-1:0] pri
    );
        logic                    found;
        logic [TSKID_WIDTH-1:0]  id;
        logic [TSKPRI_WIDTH-1:0] best;
        found = 1'b0;
        id    = '0;
        best  = '1;
        for (int i = 0; i < NUM_TASKS; i++) begin
            if (cand[i] && (!found || pri[i] < best)) begin
                found = 1'b1;
                id    = TSKID_WIDTH'(i);
                best  = pri[i];
            end
        end
        return {found, id};
    endfunction

endpackage

//--- design/rtos_core.sv
`timescale 1ns/1ps

module rtos_core
    import rtos_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  opcode_t                 cmd_op,
    input  logic [TSKID_WIDTH-1:0]  cmd_tskid,
    input  logic [PARAM_WIDTH-1:0]  cmd_param,
    output logic                    cmd_ready,
    output logic                    run_valid,
    output logic [TSKID_WIDTH-1:0]  run_tskid,
    output logic [FLGPTN_WIDTH-1:0] evtflg,
    output logic [SEM_WIDTH-1:0]    sem_count
);

    logic                                   accept;
    logic                                   acc_hold;
    opcode_t                                op_q;
    logic     [TSKID_WIDTH-1:0]             tskid_q;
    logic     [PARAM_WIDTH-1:0]             param_q;
    logic     [NUM_TASKS-1:0]               sel;

    logic     [NUM_TASKS-1:0]               wup;
    logic     [NUM_TASKS-1:0]               slp;
    logic     [NUM_TASKS-1:0]               rel_wai;
    logic     [NUM_TASKS-1:0]               dly;
    logic     [NUM_TASKS-1:0]               wai_flg;
    logic                                   sem_wai;
    logic                                   sem_sig;
    logic                                   flg_set;
    logic                                   flg_clr;

    logic     [NUM_TASKS-1:0]               busy;
    logic     [NUM_TASKS-1:0]               req_rdq;
    logic     [NUM_TASKS-1:0]               rdy_tsk;
    logic     [NUM_TASKS-1:0]               wai_sem_blk;
    logic     [NUM_TASKS-1:0]               rel_sem;
    tskstat_t [NUM_TASKS-1:0]               tskstat;
    logic     [NUM_TASKS-1:0][TSKPRI_WIDTH-1:0] tskpri;
    logic                                   tick;

    // hold off new commands while a task is moving into ready, and for the
    // cycle in which the previous command is being applied
    assign cmd_ready = !(|busy) && !acc_hold;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_hold <= 1'b0;
        end else begin
            acc_hold <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cmd_op;
            tskid_q <= cmd_tskid;
            param_q <= cmd_param;
        end
    end

    assign sel = acc_hold ? (NUM_TASKS'(1) << tskid_q) : '0;

    always_comb begin
        wup     = '0;
        slp     = '0;
        rel_wai = '0;
        dly     = '0;
        wai_flg = '0;
        sem_wai = 1'b0;
        sem_sig = 1'b0;
        flg_set = 1'b0;
        flg_clr = 1'b0;
        case (op_q)
            OP_WUP_TSK: wup     = sel;
            OP_SLP_TSK: slp     = sel;
            OP_REL_WAI: rel_wai = sel;
            OP_DLY_TSK: dly     = sel;
            OP_WAI_FLG: wai_flg = sel;
            OP_WAI_SEM: sem_wai = acc_hold;
            OP_SIG_SEM: sem_sig = acc_hold;
            OP_SET_FLG: flg_set = acc_hold;
            OP_CLR_FLG: flg_clr = acc_hold;
            default: begin
            end
        endcase
    end

    for (genvar i = 0; i < NUM_TASKS; i++) begin : g_task
        rtos_task #(
            .TSKID(i)
        ) i_task (
            .clk            (clk),
            .reset          (reset),
            .tick           (tick),
            .rel_tsk        (rel_sem[i]),
            .rdy_tsk        (rdy_tsk[i]),
            .wup_tsk        (wup[i]),
            .slp_tsk        (slp[i]),
            .rel_wai        (rel_wai[i]),
            .dly_tsk        (dly[i]),
            .dly_tsk_dlytim (param_q[RELTIM_WIDTH-1:0]),
            .wai_sem        (wai_sem_blk[i]),
            .wai_flg        (wai_flg[i]),
            .wai_flg_wfmode (param_q[WFMODE_BIT]),
            .wai_flg_flgptn (param_q[FLGPTN_WIDTH-1:0]),
            .evtflg_flgptn  (evtflg),
            .busy           (busy[i]),
            .tskpri         (tskpri[i]),
            .tskstat        (tskstat[i]),
            .req_rdq        (req_rdq[i])
        );
    end

    rtos_ready_queue i_ready_queue (
        .clk       (clk),
        .reset     (reset),
        .req_rdq   (req_rdq),
        .tskstat   (tskstat),
        .tskpri    (tskpri),
        .rdy_tsk   (rdy_tsk),
        .run_valid (run_valid),
        .run_tskid (run_tskid)
    );

    rtos_semaphore i_semaphore (
        .clk         (clk),
        .reset       (reset),
        .wai_req     (sem_wai),
        .sig_req     (sem_sig),
        .req_tskid   (tskid_q),
        .tskstat     (tskstat),
        .tskpri      (tskpri),
        .wai_sem_blk (wai_sem_blk),
        .rel_sem     (rel_sem),
        .sem_count   (sem_count)
    );

    rtos_eventflag i_eventflag (
        .clk     (clk),
        .reset   (reset),
        .set_req (flg_set),
        .clr_req (flg_clr),
        .flgptn  (param_q[FLGPTN_WIDTH-1:0]),
        .evtflg  (evtflg),
        .tick    (tick)
    );

endmodule

//--- design/rtos_eventflag.sv
`timescale 1ns/1ps

module rtos_eventflag
    import rtos_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    set_req,
    input  logic                    clr_req,
    input  logic [FLGPTN_WIDTH-1:0] flgptn,
    output logic [FLGPTN_WIDTH-1:0] evtflg,
    output logic                    tick
);

    logic [FLGPTN_WIDTH-1:0]   flg_reg;
    logic [TICK_CNT_WIDTH-1:0] div_cnt;

    // the pending update is forwarded so a flag waiter sees a set in the
    // same cycle as the request
    always_comb begin
        evtflg = flg_reg;
        if (set_req) begin
            evtflg = flg_reg | flgptn;
        end else if (clr_req) begin
            evtflg = flg_reg & flgptn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flg_reg <= '0;
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            flg_reg <= evtflg;
            tick    <= (div_cnt == TICK_CNT_WIDTH'(TICK_DIV - 1));
            if (div_cnt == TICK_CNT_WIDTH'(TICK_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/rtos_ready_queue.sv
`timescale 1ns/1ps

module rtos_ready_queue
    import rtos_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic     [NUM_TASKS-1:0]               req_rdq,
    input  tskstat_t [NUM_TASKS-1:0]               tskstat,
    input  logic     [NUM_TASKS-1:0][TSKPRI_WIDTH-1:0] tskpri,
    output logic     [NUM_TASKS-1:0]               rdy_tsk,
    output logic                                   run_valid,
    output logic     [TSKID_WIDTH-1:0]             run_tskid
);

    logic [NUM_TASKS-1:0] ready_mask;
    logic [TSKID_WIDTH:0] pick;

    always_comb begin
        for (int i = 0; i < NUM_TASKS; i++) begin
            rdy_tsk[i] = req_rdq[i];

            // a task being admitted this cycle counts as ready already, so the
            // running task follows the state change on the same edge
            ready_mask[i] = rdy_tsk[i] || (tskstat[i] == TS_READY);
        end
    end

    assign pick = pick_task(ready_mask, tskpri);

    always_ff @(posedge clk) begin
        if (reset) begin
            run_valid <= 1'b0;
            run_tskid <= '0;
        end else begin
            run_valid <= pick[TSKID_WIDTH];
            run_tskid <= pick[TSKID_WIDTH-1:0];
        end
    end

endmodule

//--- design/rtos_semaphore.sv
`timescale 1ns/1ps

module rtos_semaphore
    import rtos_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   wai_req,
    input  logic                                   sig_req,
    input  logic     [TSKID_WIDTH-1:0]             req_tskid,
    input  tskstat_t [NUM_TASKS-1:0]               tskstat,
    input  logic     [NUM_TASKS-1:0][TSKPRI_WIDTH-1:0] tskpri,
    output logic     [NUM_TASKS-1:0]               wai_sem_blk,
    output logic     [NUM_TASKS-1:0]               rel_sem,
    output logic     [SEM_WIDTH-1:0]               sem_count
);

    logic [NUM_TASKS-1:0] waiters;
    logic [TSKID_WIDTH:0] pick;
    logic                 has_waiter;

    always_comb begin
        for (int i = 0; i < NUM_TASKS; i++) begin
            waiters[i] = (tskstat[i] == TS_WAISEM);
        end
    end

    assign pick       = pick_task(waiters, tskpri);
    assign has_waiter = pick[TSKID_WIDTH];

    always_comb begin
        wai_sem_blk = '0;
        rel_sem     = '0;

        // no resource left so the caller has to block
        if (wai_req && sem_count == '0) begin
            wai_sem_blk[req_tskid] = 1'b1;
        end

        // a signal hands the resource straight to the best waiter
        if (sig_req && has_waiter) begin
            rel_sem[pick[TSKID_WIDTH-1:0]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sem_count <= SEM_INIT;
        end else if (wai_req && sem_count != '0) begin
            sem_count <= sem_count - 1'b1;
        end else if (sig_req && !has_waiter && sem_count != SEM_MAX) begin
            sem_count <= sem_count + 1'b1;
        end
    end

endmodule

//--- list.f
common/rtos_pkg.sv
task/rtos_task.sv
design/rtos_ready_queue.sv
design/rtos_semaphore.sv
design/rtos_eventflag.sv
design/rtos_core.sv
tb/rtos_checker.sv
tb/rtos_core_tb.sv

//--- task/rtos_task.sv
`timescale 1ns/1ps

module rtos_task
    import rtos_pkg::*;
#(
    parameter int TSKID = 0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    tick,
    input  logic                    rel_tsk,
    input  logic                    rdy_tsk,
    input  logic                    wup_tsk,
    input  logic                    slp_tsk,
    input  logic                    rel_wai,
    input  logic                    dly_tsk,
    input  logic [RELTIM_WIDTH-1:0] dly_tsk_dlytim,
    input  logic                    wai_sem,
    input  logic                    wai_flg,
    input  logic                    wai_flg_wfmode,
    input  logic [FLGPTN_WIDTH-1:0] wai_flg_flgptn,
    input  logic [FLGPTN_WIDTH-1:0] evtflg_flgptn,
    output logic                    busy,
    output logic [TSKPRI_WIDTH-1:0] tskpri,
    output tskstat_t                tskstat,
    output logic                    req_rdq
);

    tskstat_t                state;
    tskstat_t                state_next;
    logic                    flg_wfmode;
    logic [FLGPTN_WIDTH-1:0] flg_flgptn;
    logic [FLGPTN_WIDTH-1:0] flg_match;
    logic                    flg_hit;
    logic                    waiting;
    logic [RELTIM_WIDTH-1:0] dlytim;

    assign flg_match = evtflg_flgptn & flg_flgptn;
    assign flg_hit   = ((flg_wfmode == WF_AND) && (flg_match == flg_flgptn))
                    || ((flg_wfmode == WF_OR) && (flg_match != '0));

    // release-wait only acts on a task that is actually blocked
    assign waiting = (state == TS_DELAY) || (state == TS_WAISEM) || (state == TS_WAIFLG);

    always_comb begin
        state_next = state;

        case (state)
            TS_WAIFLG: begin
                if (flg_hit) begin
                    state_next = TS_REQRDY;
                end
            end
            TS_DELAY: begin
                if (dlytim == '0) begin
                    state_next = TS_REQRDY;
                end
            end
            default: begin
            end
        endcase

        if (rel_tsk || wup_tsk) begin
            state_next = TS_REQRDY;
        end else if (slp_tsk) begin
            state_next = TS_SLEEP;
        end else if (rel_wai && waiting) begin
            state_next = TS_REQRDY;
        end else if (dly_tsk) begin
            state_next = TS_DELAY;
        end else if (wai_sem) begin
            state_next = TS_WAISEM;
        end else if (wai_flg) begin
            state_next = TS_WAIFLG;
        end

        // admission by the ready queue overrides everything else
        if (rdy_tsk) begin
            state_next = TS_READY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TS_SLEEP;
            req_rdq <= 1'b0;
            tskpri  <= TSKPRI_WIDTH'(TSKID);
            dlytim  <= '0;
        end else begin
            state   <= state_next;
            req_rdq <= (state_next == TS_REQRDY);
            if (dly_tsk) begin
                dlytim <= dly_tsk_dlytim;
            end else if (tick && state == TS_DELAY && dlytim != '0) begin
                dlytim <= dlytim - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wai_flg) begin
            flg_wfmode <= wai_flg_wfmode;
            flg_flgptn <= wai_flg_flgptn;
        end
    end

    assign busy    = (state_next == TS_REQRDY);
    assign tskstat = state;

endmodule

//--- tb/rtos_checker.sv
`timescale 1ns/1ps

module rtos_checker
    import rtos_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  logic                    run_valid,
    input  logic [TSKID_WIDTH-1:0]  run_tskid,
    input  logic [FLGPTN_WIDTH-1:0] evtflg,
    input  logic [SEM_WIDTH-1:0]    sem_count,
    input  logic                    chk_strobe,
    input  logic                    exp_run_valid,
    input  logic [TSKID_WIDTH-1:0]  exp_run_tskid,
    input  logic [FLGPTN_WIDTH-1:0] exp_evtflg,
    input  logic [SEM_WIDTH-1:0]    exp_sem_count,
    output int                      value_errors,
    output int                      handshake_errors
);

    localparam int STALL_LIMIT = 20;

    int   stall_cycles;
    logic accepted;

    task automatic check_field(input string field, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, field, got, want);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            value_errors = 0;
        end else if (chk_strobe) begin
            check_field("run_valid", 16'(run_valid), 16'(exp_run_valid));
            // with no running task the id carries no meaning
            if (exp_run_valid) begin
                check_field("run_tskid", 16'(run_tskid), 16'(exp_run_tskid));
            end
            check_field("evtflg", 16'(evtflg), 16'(exp_evtflg));
            check_field("sem_count", 16'(sem_count), 16'(exp_sem_count));
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            handshake_errors = 0;
            stall_cycles     = 0;
            accepted         = 1'b0;
        end else begin
            // the core must hold off the next command for one cycle after an accept
            if (accepted && cmd_ready) begin
                $display("[FAIL] %0t ns: cmd_ready is high in the cycle after an accept", $time);
                handshake_errors++;
            end
            if (cmd_valid && !cmd_ready) begin
                stall_cycles++;
                if (stall_cycles == STALL_LIMIT) begin
                    $display("a pending command was not accepted within %0d cycles, at %0t ns",
                             STALL_LIMIT, $time);
                    handshake_errors++;
                end
            end else begin
                stall_cycles = 0;
            end
            accepted = cmd_valid && cmd_ready;
        end
    end

endmodule

//--- tb/rtos_core_tb.sv
`timescale 1ns/1ps

module rtos_core_tb
    import rtos_pkg::*;
();

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 4;
    localparam int SETTLE       = 3;
    localparam int STALL_LIMIT  = 20;

    logic                    clk;
    logic                    reset;
    logic                    cmd_valid;
    opcode_t                 cmd_op;
    logic [TSKID_WIDTH-1:0]  cmd_tskid;
    logic [PARAM_WIDTH-1:0]  cmd_param;
    logic                    cmd_ready;
    logic                    run_valid;
    logic [TSKID_WIDTH-1:0]  run_tskid;
    logic [FLGPTN_WIDTH-1:0] evtflg;
    logic [SEM_WIDTH-1:0]    sem_count;

    logic                    chk_strobe;
    logic                    exp_run_valid;
    logic [TSKID_WIDTH-1:0]  exp_run_tskid;
    logic [FLGPTN_WIDTH-1:0] exp_evtflg;
    logic [SEM_WIDTH-1:0]    exp_sem_count;
    int                      value_errors;
    int                      handshake_errors;

    opcode_t                 row_op[$];
    logic [TSKID_WIDTH-1:0]  row_tskid[$];
    logic [PARAM_WIDTH-1:0]  row_param[$];
    int                      row_wait[$];
    logic                    row_run_valid[$];
    logic [TSKID_WIDTH-1:0]  row_run_tskid[$];
    logic [FLGPTN_WIDTH-1:0] row_evtflg[$];
    logic [SEM_WIDTH-1:0]    row_sem_count[$];

    int cycle_count = 0;
    int cycle_limit = 1000000;

    rtos_core i_rtos_core (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_tskid (cmd_tskid),
        .cmd_param (cmd_param),
        .cmd_ready (cmd_ready),
        .run_valid (run_valid),
        .run_tskid (run_tskid),
        .evtflg    (evtflg),
        .sem_count (sem_count)
    );

    rtos_checker i_rtos_checker (
        .clk              (clk),
        .reset            (reset),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .run_valid        (run_valid),
        .run_tskid        (run_tskid),
        .evtflg           (evtflg),
        .sem_count        (sem_count),
        .chk_strobe       (chk_strobe),
        .exp_run_valid    (exp_run_valid),
        .exp_run_tskid    (exp_run_tskid),
        .exp_evtflg       (exp_evtflg),
        .exp_sem_count    (exp_sem_count),
        .value_errors     (value_errors),
        .handshake_errors (handshake_errors)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run was stopped after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic add_row(input opcode_t op, input int tskid, input int param,
                           input int wait_cycles, input int want_valid, input int want_tskid,
                           input int want_flg, input int want_sem);
        row_op.push_back(op);
        row_tskid.push_back(TSKID_WIDTH'(tskid));
        row_param.push_back(PARAM_WIDTH'(param));
        row_wait.push_back(wait_cycles);
        row_run_valid.push_back(1'(want_valid));
        row_run_tskid.push_back(TSKID_WIDTH'(want_tskid));
        row_evtflg.push_back(FLGPTN_WIDTH'(want_flg));
        row_sem_count.push_back(SEM_WIDTH'(want_sem));
    endtask

    // op, task, param, wait, run_valid, run_tskid, evtflg, sem_count
    // priority equals task id and the lower value runs first
    task automatic build_table();
        add_row(OP_SET_FLG, 0, 16'h0000, SETTLE, 0, 0, 8'h00, 1);
        add_row(OP_WUP_TSK, 2, 16'h0000, SETTLE, 1, 2, 8'h00, 1);
        add_row(OP_WUP_TSK, 1, 16'h0000, SETTLE, 1, 1, 8'h00, 1);
        add_row(OP_SLP_TSK, 1, 16'h0000, SETTLE, 1, 2, 8'h00, 1);
        add_row(OP_REL_WAI, 1, 16'h0000, SETTLE, 1, 2, 8'h00, 1);
        add_row(OP_DLY_TSK, 2, 16'h0003, SETTLE, 0, 0, 8'h00, 1);
        // a harmless set gives task 2 time to come back from its 3 tick delay
        add_row(OP_SET_FLG, 0, 16'h0000, (3 + 1) * TICK_DIV + SETTLE, 1, 2, 8'h00, 1);
        add_row(OP_WUP_TSK, 0, 16'h0000, SETTLE, 1, 0, 8'h00, 1);
        add_row(OP_WAI_SEM, 0, 16'h0000, SETTLE, 1, 0, 8'h00, 0);
        add_row(OP_WAI_SEM, 3, 16'h0000, SETTLE, 1, 0, 8'h00, 0);
        add_row(OP_SIG_SEM, 0, 16'h0000, SETTLE, 1, 0, 8'h00, 0);
        add_row(OP_SIG_SEM, 0, 16'h0000, SETTLE, 1, 0, 8'h00, 1);
        add_row(OP_SLP_TSK, 0, 16'h0000, SETTLE, 1, 2, 8'h00, 1);
        // task 3 shows up here only if the first signal released it
        add_row(OP_SLP_TSK, 2, 16'h0000, SETTLE, 1, 3, 8'h00, 1);
        add_row(OP_WAI_FLG, 3, 16'h0005, SETTLE, 0, 0, 8'h00, 1);
        add_row(OP_SET_FLG, 0, 16'h0001, SETTLE, 0, 0, 8'h01, 1);
        add_row(OP_SET_FLG, 0, 16'h0004, SETTLE, 1, 3, 8'h05, 1);
        add_row(OP_CLR_FLG, 0, 16'h00fe, SETTLE, 1, 3, 8'h04, 1);
        add_row(OP_WAI_FLG, 3, 16'h0104, SETTLE, 1, 3, 8'h04, 1);
        // only the OR mode can release a wait on 0x06 while evtflg holds 0x04
        add_row(OP_WAI_FLG, 3, 16'h0106, SETTLE, 1, 3, 8'h04, 1);
        // a wait of zero chains the next row onto the accept edge of this one
        add_row(OP_WUP_TSK, 2, 16'h0000, 0, 0, 0, 8'h00, 0);
        add_row(OP_SET_FLG, 0, 16'h0080, SETTLE, 1, 2, 8'h84, 1);
    endtask

    task automatic apply_row(input int i);
        cmd_valid <= 1'b1;
        cmd_op    <= row_op[i];
        cmd_tskid <= row_tskid[i];
        cmd_param <= row_param[i];
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (row_wait[i] != 0) begin
            cmd_valid <= 1'b0;
            repeat (row_wait[i]) @(posedge clk);
            exp_run_valid <= row_run_valid[i];
            exp_run_tskid <= row_run_tskid[i];
            exp_evtflg    <= row_evtflg[i];
            exp_sem_count <= row_sem_count[i];
            chk_strobe    <= 1'b1;
            @(posedge clk);
            chk_strobe    <= 1'b0;
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_op        = OP_WUP_TSK;
        cmd_tskid     = '0;
        cmd_param     = '0;
        chk_strobe    = 1'b0;
        exp_run_valid = 1'b0;
        exp_run_tskid = '0;
        exp_evtflg    = '0;
        exp_sem_count = '0;

        build_table();
        cycle_limit = RESET_CYCLES + 4;
        foreach (row_wait[i]) begin
            cycle_limit += row_wait[i] + 1 + STALL_LIMIT;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < row_op.size(); i++) begin
            apply_row(i);
        end
        repeat (2) @(posedge clk);

        $display("rtos_core_tb: %0d rows applied, %0d value errors, %0d handshake errors",
                 row_op.size(), value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
